// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vend
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim.f
verilog/vend_pkg.sv
verilog/vend_status_if.sv
verilog/vend_control.sv
verilog/coin_credit.sv
verilog/dispense_timer.sv
verilog/digit_scan.sv
verilog/vend_top.sv
verif/vend_checker.sv
verif/tb_vend.sv

// File: verif/tb_vend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vend;

    localparam int WAIT_LIMIT = 100;

    logic       clk = 1'b0;
    logic       reset, sale_mode, op_start, confirm, cancel, item1, item2;
    logic       buy, coin_half, coin_five;
    logic [7:0] seg, an;
    logic       hold_ind, sale_ind, change_ind, dispense_ind;
    int         timeouts = 0;
    int         cases = 0;

    always #2 clk = ~clk;

    vend_top dut_i (.*);

    vend_checker checker_i (.*);

    function automatic logic ind_value(input string sel);
        if (sel == "hold")
            return hold_ind;
        if (sel == "sale")
            return sale_ind;
        return dispense_ind || change_ind; // Change phase
    endfunction

    task automatic wait_ind(input string name, input string sel, input logic level,
                            output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            ok = (ind_value(sel) == level);
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout in case %s: %s indicator never went to %0b", name, sel, level);
        end
    endtask

    // Small coin 1, large coin 10, a coin past 31 is ignored
    function automatic int add_coin(input int credit, input byte c);
        int value;
        value = (c == "H") ? 1 : 10;
        return (credit + value > 31) ? credit : credit + value;
    endfunction

    task automatic run_case(input string name, input string op, input int count,
                            input string coins, input int exp_change, input int exp_disp,
                            output logic ok);
        int credit;
        int phases_before;
        int i;
        credit = 0;
        phases_before = checker_i.phases;
        checker_i.start_case(name);
        sale_mode <= 1'b1;
        op_start  <= 1'b1;
        wait_ind(name, "hold", 1'b1, ok); // Choosing
        if (ok && op == "back") begin
            op_start <= 1'b0;
            wait_ind(name, "hold", 1'b0, ok);
            checker_i.compare(name, "sale_ind after backing out", 1, sale_ind);
        end else if (ok) begin
            confirm <= 1'b1;
            @(posedge clk);
            confirm <= 1'b0;
            for (i = 0; i < count; i++) begin
                @(posedge clk);
                buy       <= 1'b1;
                coin_half <= (coins.getc(i) == "H");
                coin_five <= (coins.getc(i) == "F");
                credit = add_coin(credit, coins.getc(i));
            end
            @(posedge clk);
            {buy, coin_half, coin_five} <= 3'b000;
            checker_i.check_display(name, credit);
            item1  <= (op == "item1");
            item2  <= (op == "item2" || op == "short2");
            cancel <= (op == "cancel");
            if (op == "short2") begin
                repeat (8) begin
                    @(posedge clk);
                    checker_i.compare(name, "hold_ind while short", 1, hold_ind);
                    checker_i.compare(name, "dispense_ind while short", 0, dispense_ind);
                end
                buy       <= 1'b1;
                coin_half <= 1'b1;
                credit = add_coin(credit, "H");
                @(posedge clk);
                {buy, coin_half} <= 2'b00;
            end
            if (op == "cancel" && credit == 0) begin
                wait_ind(name, "hold", 1'b0, ok); // Straight back to idle
            end else begin
                wait_ind(name, "phase", 1'b1, ok);
                if (ok) begin
                    checker_i.compare(name, "dispense_ind", exp_disp, dispense_ind);
                    checker_i.compare(name, "change_ind", exp_change != 0, change_ind);
                    checker_i.check_display(name, exp_change);
                    wait_ind(name, "hold", 1'b0, ok);
                end
            end
        end
        {item1, item2, cancel, sale_mode, op_start} <= 5'b00000;
        if (ok)
            wait_ind(name, "sale", 1'b0, ok);
        if (ok) begin
            @(posedge clk);
            checker_i.compare(name, "change phases",
                              (op == "back" || (op == "cancel" && credit == 0)) ? 0 : 1,
                              checker_i.phases - phases_before);
            checker_i.check_idle(name);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    count, exp_change, exp_disp;
        logic  ok;
        string line, name, op, coins;
        reset = 1'b0;
        {sale_mode, op_start, confirm, cancel, item1, item2, buy, coin_half, coin_five} = '0;
        ok = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        checker_i.check_idle("after_reset");
        fd = $fopen("verif/vend_cases.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
            $display("Could not open the case file verif/vend_cases.txt");
        end
        while (ok && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %s %d %s %d %d", name, op, count, coins, exp_change, exp_disp);
            if (n == 6 && line.getc(0) != "#") begin
                cases++;
                run_case(name, op, count, coins, exp_change, exp_disp, ok);
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("Cases %0d, checks %0d, errors %0d, timeouts %0d",
                 cases, checker_i.checks, checker_i.errors, timeouts);
        if (ok && cases > 0 && checker_i.errors == 0 && timeouts == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/vend_cases.txt
# name  op  coin_count  coins  expected_change  expected_dispense  (amounts in half-units)
# op is item1, item2, cancel, short2 or back; coin H is small, F is large, - is none
item1_exact     item1   5  HHHHH      0   1
item2_change    item2   2  FF         10  1
cancel_refund   cancel  3  HHH        3   0
cancel_empty    cancel  0  -          0   0
item2_short     short2  9  HHHHHHHHH  0   1
back_out        back    0  -          0   0
item1_large     item1   1  F          5   1
item2_mixed     item2   4  FHHH       3   1
item1_big       item1   3  FFF        25  1
item2_ceiling   item2   5  FFFHF      21  1
cancel_full     cancel  3  FFF        30  0

// File: verif/vend_checker.sv
`timescale 1ns/1ns
`default_nettype none

module vend_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] seg,
    input  logic [7:0] an,
    input  logic       hold_ind,
    input  logic       sale_ind,
    input  logic       change_ind,
    input  logic       dispense_ind
);

    localparam int PHASE_CYCLES = 16; // Change phase length in clock cycles

    string      case_name = "reset";
    int         checks = 0;
    int         errors = 0;
    int         phases = 0;
    int         phase_len = 0;
    logic [1:0] phase_kind = 2'b00; // Dispense and change indicators at phase start

    task automatic start_case(input string name);
        case_name = name;
    endtask

    task automatic compare(input string name, input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_idle(input string name);
        compare(name, "hold_ind", 0, hold_ind);
        compare(name, "sale_ind", 0, sale_ind);
        compare(name, "change_ind", 0, change_ind);
        compare(name, "dispense_ind", 0, dispense_ind);
        compare(name, "an", 8'hFF, an); // Display blank
        compare(name, "seg", 8'hFF, seg);
    endtask

    // Active-low segments g to a
    function automatic int seg_value(input logic [6:0] segs);
        case (segs)
            7'h40: return 0;
            7'h79: return 1;
            7'h24: return 2;
            7'h30: return 3;
            7'h19: return 4;
            7'h12: return 5;
            7'h02: return 6;
            7'h78: return 7;
            7'h00: return 8;
            7'h10: return 9;
            7'h7F: return -1; // Blank
            default: return -2;
        endcase
    endfunction

    // Gathers one full scan and compares the amount in half-units
    task automatic check_display(input string name, input int exp);
        logic [7:0] cap [3];
        logic [2:0] seen;
        int         cycles;
        int         k;
        int         tens;
        int         units;
        int         half;
        seen = '0;
        cycles = 0;
        @(posedge clk); // May still hold the previous state's value
        while (seen != 3'b111 && cycles < 40) begin
            @(posedge clk);
            cycles++;
            for (k = 0; k < 3; k++) begin
                if (an == ~(8'b1 << k)) begin
                    cap[k] = seg;
                    seen[k] = 1'b1;
                end
            end
        end
        if (seen != 3'b111) begin
            errors++;
            $display("Display in case %s never scanned all three digits", name);
        end else begin
            tens = seg_value(cap[2][6:0]);
            units = seg_value(cap[1][6:0]);
            half = seg_value(cap[0][6:0]);
            if (tens == -1)
                tens = 0; // Leading blank
            if (tens < 0 || units < 0 || (half != 0 && half != 5) ||
                cap[1][7] || !cap[0][7]) begin
                errors++;
                $display("Display in case %s shows an unreadable amount", name);
            end else begin
                compare(name, "display", exp, tens * 20 + units * 2 + (half == 5 ? 1 : 0));
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            phase_len <= 0;
        end else if (dispense_ind || change_ind) begin
            if (phase_len == 0) begin
                phases <= phases + 1;
                phase_kind <= {dispense_ind, change_ind};
            end else begin
                compare(case_name, "indicators held in change phase", phase_kind,
                        {dispense_ind, change_ind});
            end
            phase_len <= phase_len + 1;
            compare(case_name, "hold_ind in change phase", 1, hold_ind);
        end else if (phase_len != 0) begin
            compare(case_name, "change phase cycles", PHASE_CYCLES, phase_len);
            phase_len <= 0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/coin_credit.sv
`timescale 1ns/1ns
`default_nettype none

module coin_credit (
    input  logic       clk,
    input  logic       reset,
    input  logic       buy,
    input  logic       coin_half,
    input  logic       coin_five,
    vend_status_if.coin st
);

    vend_pkg::credit_t           coin_value;
    logic [vend_pkg::CREDIT_W:0] sum; // Carry kept for the ceiling check

    always_comb begin
        if (coin_half)
            coin_value = vend_pkg::COIN_HALF_VALUE;
        else if (coin_five)
            coin_value = vend_pkg::COIN_FIVE_VALUE;
        else
            coin_value = '0;
        sum = {1'b0, st.credit} + {1'b0, coin_value};
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            st.credit <= '0;
        end else if (st.state != vend_pkg::ST_PAYING) begin
            st.credit <= '0;
        end else if (buy && (sum <= vend_pkg::CREDIT_MAX)) begin
            st.credit <= sum[vend_pkg::CREDIT_W-1:0]; // Over the ceiling is ignored
        end
    end

    // Cleared on the first edge after leaving paying
    credit_idle_zero: assert property (@(posedge clk) disable iff (!reset)
        (st.state != vend_pkg::ST_PAYING && $past(st.state) != vend_pkg::ST_PAYING)
        |-> (st.credit == '0));

endmodule

`default_nettype wire

// File: verilog/digit_scan.sv
`timescale 1ns/1ns
`default_nettype none

module digit_scan (
    input  logic        clk,
    input  logic        reset,
    vend_status_if.show st,
    output logic [7:0]  seg,
    output logic [7:0]  an
);

    logic [vend_pkg::SCAN_W-1:0]   tick;
    logic [1:0]                    digit_sel;
    logic                          show_on;
    vend_pkg::credit_t             amount;
    logic [vend_pkg::CREDIT_W-2:0] whole; // Whole units
    logic [3:0]                    half_digit;
    logic [3:0]                    units;
    logic [3:0]                    tens;
    logic [7:0]                    digit_seg;

    always_comb begin
        show_on = (st.state == vend_pkg::ST_PAYING) || (st.state == vend_pkg::ST_CHANGE);
        amount  = (st.state == vend_pkg::ST_CHANGE) ? st.change : st.credit;
    end

    // Split half-units into tens, units and the half digit
    always_comb begin
        whole      = amount[vend_pkg::CREDIT_W-1:1];
        half_digit = amount[0] ? 4'd5 : 4'd0;
        if (whole >= 4'd10) begin
            tens  = 4'd1;
            units = whole - 4'd10;
        end else begin
            tens  = 4'd0;
            units = whole;
        end
    end

    always_comb begin
        case (digit_sel)
            2'd0: digit_seg = vend_pkg::seg_digit(half_digit, 1'b0);
            2'd1: digit_seg = vend_pkg::seg_digit(units, 1'b1); // Point after the units
            default: begin
                if (tens == 4'd0)
                    digit_seg = vend_pkg::SEG_BLANK; // No leading zero
                else
                    digit_seg = vend_pkg::seg_digit(tens, 1'b0);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            tick      <= '0;
            digit_sel <= 2'd0;
        end else if (tick == vend_pkg::SCAN_LAST) begin
            tick <= '0;
            if (digit_sel == vend_pkg::DIGIT_LAST)
                digit_sel <= 2'd0;
            else
                digit_sel <= digit_sel + 2'd1;
        end else begin
            tick <= tick + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            seg <= vend_pkg::SEG_BLANK;
            an  <= 8'hFF;
        end else if (!show_on) begin
            seg <= vend_pkg::SEG_BLANK;
            an  <= 8'hFF; // Nothing lit
        end else begin
            seg <= digit_seg;
            an  <= ~(8'b1 << digit_sel); // One anode low at a time
        end
    end

endmodule

`default_nettype wire

// File: verilog/dispense_timer.sv
`timescale 1ns/1ns
`default_nettype none

module dispense_timer (
    input  logic        clk,
    input  logic        reset,
    vend_status_if.timer st,
    output logic        dispense_ind
);

    logic [vend_pkg::DISPENSE_W-1:0] hold_cnt;
    logic                            in_change;

    assign in_change = (st.state == vend_pkg::ST_CHANGE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            hold_cnt <= '0;
        end else if (in_change) begin
            hold_cnt <= hold_cnt + 1'b1;
        end else begin
            hold_cnt <= '0; // Restart for the next sale
        end
    end

    // High in the last cycle of the change phase
    assign st.done = in_change && (hold_cnt == vend_pkg::DISPENSE_LAST);

    assign dispense_ind = in_change && st.bought;

    // Phase ends on the edge after its only done pulse
    done_pulse: assert property (@(posedge clk) disable iff (!reset)
        st.done |=> !in_change);

endmodule

`default_nettype wire

// File: verilog/vend_control.sv
`timescale 1ns/1ns
`default_nettype none

module vend_control (
    input  logic       clk,
    input  logic       reset,
    input  logic       sale_mode,
    input  logic       op_start,
    input  logic       confirm,
    input  logic       cancel,
    input  logic       item1,
    input  logic       item2,
    vend_status_if.ctrl st,
    output logic       hold_ind,
    output logic       sale_ind,
    output logic       change_ind
);

    vend_pkg::vend_state_t next_state;
    vend_pkg::credit_t     sel_price;
    logic                  paid;
    logic                  enter_change;

    always_comb begin
        sel_price = item1 ? vend_pkg::PRICE_ITEM1 : vend_pkg::PRICE_ITEM2; // item1 wins
        paid = (item1 || item2) && (st.credit >= sel_price);
    end

    always_comb begin
        next_state = st.state;
        case (st.state)
            vend_pkg::ST_IDLE: begin
                if (sale_mode)
                    next_state = vend_pkg::ST_FOR_SALE;
            end
            vend_pkg::ST_FOR_SALE: begin
                if (!sale_mode)
                    next_state = vend_pkg::ST_IDLE;
                else if (op_start)
                    next_state = vend_pkg::ST_CHOOSING;
            end
            vend_pkg::ST_CHOOSING: begin
                if (!op_start)
                    next_state = vend_pkg::ST_FOR_SALE; // Customer backed out
                else if (confirm)
                    next_state = vend_pkg::ST_PAYING;
            end
            vend_pkg::ST_PAYING: begin
                if (cancel) begin
                    if (st.credit != '0)
                        next_state = vend_pkg::ST_CHANGE; // Refund
                    else
                        next_state = vend_pkg::ST_IDLE;
                end else if (paid) begin
                    next_state = vend_pkg::ST_CHANGE;
                end
            end
            vend_pkg::ST_CHANGE: begin
                if (st.done)
                    next_state = vend_pkg::ST_IDLE;
            end
            default: next_state = vend_pkg::ST_IDLE;
        endcase
    end

    assign enter_change = (st.state == vend_pkg::ST_PAYING) &&
                          (next_state == vend_pkg::ST_CHANGE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            st.state  <= vend_pkg::ST_IDLE;
            st.bought <= 1'b0;
        end else begin
            st.state <= next_state;
            if (enter_change)
                st.bought <= !cancel;
        end
    end

    always_ff @(posedge clk) begin
        if (enter_change)
            st.change <= cancel ? st.credit : st.credit - sel_price;
    end

    assign sale_ind   = (st.state != vend_pkg::ST_IDLE);
    assign hold_ind   = (st.state == vend_pkg::ST_CHOOSING) ||
                        (st.state == vend_pkg::ST_PAYING) ||
                        (st.state == vend_pkg::ST_CHANGE);
    assign change_ind = (st.state == vend_pkg::ST_CHANGE) && (st.change != '0);

    state_legal: assert property (@(posedge clk) disable iff (!reset)
        st.state inside {vend_pkg::ST_IDLE, vend_pkg::ST_FOR_SALE, vend_pkg::ST_CHOOSING,
                         vend_pkg::ST_PAYING, vend_pkg::ST_CHANGE});

    // Latched change comes from the credit seen in the paying state
    change_bound: assert property (@(posedge clk) disable iff (!reset)
        (st.state == vend_pkg::ST_CHANGE && $past(st.state) == vend_pkg::ST_PAYING)
        |-> (st.change <= $past(st.credit)));

endmodule

`default_nettype wire

// File: verilog/vend_pkg.sv
`default_nettype none

package vend_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FOR_SALE,
        ST_CHOOSING,
        ST_PAYING,
        ST_CHANGE
    } vend_state_t;

    localparam int CREDIT_W = 5;
    typedef logic [CREDIT_W-1:0] credit_t; // Amount in half-unit steps

    localparam credit_t COIN_HALF_VALUE = 5'd1;
    localparam credit_t COIN_FIVE_VALUE = 5'd10;
    localparam credit_t PRICE_ITEM1 = 5'd5;
    localparam credit_t PRICE_ITEM2 = 5'd10;
    localparam logic [CREDIT_W:0] CREDIT_MAX = 6'd31; // One bit wider than credit

    localparam int DISPENSE_CYCLES = 16;
    localparam int DISPENSE_W = $clog2(DISPENSE_CYCLES);
    localparam logic [DISPENSE_W-1:0] DISPENSE_LAST = DISPENSE_W'(DISPENSE_CYCLES - 1);

    localparam int SCAN_DIV = 4;
    localparam int SCAN_W = $clog2(SCAN_DIV);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_DIV - 1);
    localparam int SCAN_DIGITS = 3; // Half, units, tens
    localparam logic [1:0] DIGIT_LAST = 2'(SCAN_DIGITS - 1);

    localparam logic [7:0] SEG_BLANK = 8'hFF;

    // Active low, bit 7 is the decimal point
    function automatic logic [7:0] seg_digit(input logic [3:0] value, input logic dp);
        logic [6:0] segs;
        case (value)
            4'd0: segs = 7'b100_0000;
            4'd1: segs = 7'b111_1001;
            4'd2: segs = 7'b010_0100;
            4'd3: segs = 7'b011_0000;
            4'd4: segs = 7'b001_1001;
            4'd5: segs = 7'b001_0010;
            4'd6: segs = 7'b000_0010;
            4'd7: segs = 7'b111_1000;
            4'd8: segs = 7'b000_0000;
            4'd9: segs = 7'b001_0000;
            default: segs = 7'b111_1111;
        endcase
        return {~dp, segs};
    endfunction

endpackage

`default_nettype wire

// File: verilog/vend_status_if.sv
`timescale 1ns/1ns
`default_nettype none

interface vend_status_if;

    vend_pkg::vend_state_t state;
    vend_pkg::credit_t     credit; // Coins inserted so far
    vend_pkg::credit_t     change; // Held through the change phase
    logic                  bought; // Change phase follows a purchase
    logic                  done;   // Last cycle of the change phase

    modport ctrl (
        output state, change, bought,
        input  credit, done
    );

    modport coin ( // Credit accumulator side
        output credit,
        input  state
    );

    modport timer (
        output done,
        input  state, bought
    );

    modport show (
        input state, credit, change
    );

endinterface

`default_nettype wire

// File: verilog/vend_top.sv
`timescale 1ns/1ns
`default_nettype none

module vend_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       sale_mode,
    input  logic       op_start,
    input  logic       confirm,
    input  logic       cancel,
    input  logic       item1,
    input  logic       item2,
    input  logic       buy,
    input  logic       coin_half,
    input  logic       coin_five,
    output logic [7:0] seg,
    output logic [7:0] an,
    output logic       hold_ind,
    output logic       sale_ind,
    output logic       change_ind,
    output logic       dispense_ind
);

    vend_status_if st_if ();

    vend_control control_i (
        .clk        (clk),
        .reset      (reset),
        .sale_mode  (sale_mode),
        .op_start   (op_start),
        .confirm    (confirm),
        .cancel     (cancel),
        .item1      (item1),
        .item2      (item2),
        .st         (st_if.ctrl),
        .hold_ind   (hold_ind),
        .sale_ind   (sale_ind),
        .change_ind (change_ind)
    );

    coin_credit credit_i (
        .clk       (clk),
        .reset     (reset),
        .buy       (buy),
        .coin_half (coin_half),
        .coin_five (coin_five),
        .st        (st_if.coin)
    );

    dispense_timer timer_i (
        .clk          (clk),
        .reset        (reset),
        .st           (st_if.timer),
        .dispense_ind (dispense_ind)
    );

    digit_scan scan_i (
        .clk   (clk),
        .reset (reset),
        .st    (st_if.show),
        .seg   (seg),
        .an    (an)
    );

endmodule

`default_nettype wire
